// File: files.f
+incdir+hdl
hdl/riscvIsaPkg.sv
hdl/datapathCtrlPkg.sv
hdl/instrDecoder.sv
hdl/execSequencer.sv
hdl/controlUnit.sv
tests/tbControlUnit.sv

// File: hdl/controlUnit.sv
// Not pipelined and the environment drops instrValid when it sees rdWrite
`include "ctrl_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire                          clk,
    input  wire                          reset,
    input  wire riscvIsaPkg::instrWord_u instr,
    input  wire                          instrValid,
    input  wire [`XLEN-1:0]              pcIn,
    input  wire                          dataReady,
    input  wire                          aluComplete,
    input  wire                          memAck,
    output logic [`XLEN-1:0]             pcOut,
    output logic [`XLEN-1:0]             immValue,
    output logic [`REG_ADDR_W-1:0]       rs1Out,
    output logic [`REG_ADDR_W-1:0]       rs2Out,
    output logic [`REG_ADDR_W-1:0]       rdOut,
    output datapathCtrlPkg::aluOp_e      aluSel,
    output datapathCtrlPkg::aSel_e       aSel,
    output datapathCtrlPkg::bSel_e       bSel,
    output datapathCtrlPkg::oSel_e       oSel,
    output logic                         aEnable,
    output logic                         bEnable,
    output logic                         rdWrite,
    output logic                         memRead
);
    import datapathCtrlPkg::*;

    // Decoder to sequencer
    aluOp_e                 aluOp;
    aluOp_e                 loadOp;
    bSel_e                  bSrc;
    oSel_e                  loadOsel;
    logic [`XLEN-1:0]       decImm;
    logic [`REG_ADDR_W-1:0] decRs1;
    logic [`REG_ADDR_W-1:0] decRs2;
    logic [`REG_ADDR_W-1:0] decRd;
    logic                   isLoad;
    logic                   usesRs2;
    logic                   supported;

    instrDecoder decoder (
        .instr     (instr),
        .aluOp     (aluOp),
        .loadOp    (loadOp),
        .bSrc      (bSrc),
        .loadOsel  (loadOsel),
        .immValue  (decImm),
        .rs1       (decRs1),
        .rs2       (decRs2),
        .rd        (decRd),
        .isLoad    (isLoad),
        .usesRs2   (usesRs2),
        .supported (supported)
    );

    execSequencer sequencer (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .dataReady   (dataReady),
        .aluComplete (aluComplete),
        .memAck      (memAck),
        .pcIn        (pcIn),
        .aluOp       (aluOp),
        .loadOp      (loadOp),
        .bSrc        (bSrc),
        .loadOsel    (loadOsel),
        .decImm      (decImm),
        .rs1         (decRs1),
        .rs2         (decRs2),
        .rd          (decRd),
        .isLoad      (isLoad),
        .usesRs2     (usesRs2),
        .supported   (supported),
        .pcOut       (pcOut),
        .immValue    (immValue),
        .rs1Out      (rs1Out),
        .rs2Out      (rs2Out),
        .rdOut       (rdOut),
        .aluSel      (aluSel),
        .aSel        (aSel),
        .bSel        (bSel),
        .oSel        (oSel),
        .aEnable     (aEnable),
        .bEnable     (bEnable),
        .rdWrite     (rdWrite),
        .memRead     (memRead)
    );

endmodule

`default_nettype wire

// File: hdl/ctrl_defines.svh
// XLEN is fixed at 32 by the RV32I word layout and PC_RESET must fit in XLEN bits
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

`default_nettype none

// Data path and program counter width
`define XLEN 32

// Register file address width, 32 registers
`define REG_ADDR_W 5

// I-type immediate field width
`define IMM12_W 12

// Shift amount field width for SLLI SRLI SRAI
`define SHAMT_W 5

// Program counter after reset
`define PC_RESET 32'h0000_0000

`default_nettype wire

`endif

// File: hdl/datapathCtrlPkg.sv
// Codes follow the external ALU and mux wiring and must match that datapath bit for bit
`include "ctrl_defines.svh"
`default_nettype none

package datapathCtrlPkg;

    // ALU operation select, load extractions sit above 15
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLL  = 5'd4,
        ALU_SRL  = 5'd5,
        ALU_AND  = 5'd8,
        ALU_XOR  = 5'd10,
        ALU_OR   = 5'd11,
        ALU_SLTU = 5'd13,
        ALU_SLT  = 5'd14,
        ALU_SRA  = 5'd15,
        ALU_LB   = 5'd16,  // Byte, sign extended
        ALU_LH   = 5'd17,  // Half word, sign extended
        ALU_LBU  = 5'd18,  // Byte, zero extended
        ALU_LHU  = 5'd19   // Half word, zero extended
    } aluOp_e;

    // Operand A mux
    typedef enum logic [1:0] {
        ASEL_DECODER = 2'd0,
        ASEL_BUS     = 2'd1   // Register data from the bus
    } aSel_e;

    // Operand B mux
    typedef enum logic [1:0] {
        BSEL_DECODER = 2'd0,
        BSEL_BUS     = 2'd1,
        BSEL_IMM     = 2'd2   // immValue from this block
    } bSel_e;

    // Output mux toward the register file
    typedef enum logic [1:0] {
        OSEL_ALU  = 2'd0,
        OSEL_REGA = 2'd1,  // Raw word for LW
        OSEL_REGB = 2'd2
    } oSel_e;

endpackage

`default_nettype wire

// File: hdl/execSequencer.sv
// One instruction in flight and instrValid must stay high until the rdWrite cycle
`include "ctrl_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module execSequencer (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          instrValid,   // Sampled in IDLE only
    input  wire                          dataReady,
    input  wire                          aluComplete,
    input  wire                          memAck,       // Used without a sync flop
    input  wire [`XLEN-1:0]              pcIn,
    input  wire datapathCtrlPkg::aluOp_e aluOp,
    input  wire datapathCtrlPkg::aluOp_e loadOp,
    input  wire datapathCtrlPkg::bSel_e  bSrc,
    input  wire datapathCtrlPkg::oSel_e  loadOsel,
    input  wire [`XLEN-1:0]              decImm,
    input  wire [`REG_ADDR_W-1:0]        rs1,
    input  wire [`REG_ADDR_W-1:0]        rs2,
    input  wire [`REG_ADDR_W-1:0]        rd,
    input  wire                          isLoad,
    input  wire                          usesRs2,
    input  wire                          supported,
    output logic [`XLEN-1:0]             pcOut,
    output logic [`XLEN-1:0]             immValue,
    output logic [`REG_ADDR_W-1:0]       rs1Out,
    output logic [`REG_ADDR_W-1:0]       rs2Out,
    output logic [`REG_ADDR_W-1:0]       rdOut,
    output datapathCtrlPkg::aluOp_e      aluSel,
    output datapathCtrlPkg::aSel_e       aSel,
    output datapathCtrlPkg::bSel_e       bSel,
    output datapathCtrlPkg::oSel_e       oSel,
    output logic                         aEnable,
    output logic                         bEnable,
    output logic                         rdWrite,
    output logic                         memRead
);
    import datapathCtrlPkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, EXECUTE, MEMORY, WRITEBACK} state_e;

    localparam logic [`XLEN-1:0] PC_STEP = 1;  // PC counts instructions

    state_e                 state;
    logic                   issue;
    logic                   dataReadySync;
    logic                   aluCompleteSync;

    // Decoded fields held while the instruction runs
    aluOp_e                 aluOpQ;
    aluOp_e                 loadOpQ;
    bSel_e                  bSrcQ;
    oSel_e                  loadOselQ;
    logic [`XLEN-1:0]       immQ;
    logic [`REG_ADDR_W-1:0] rdQ;
    logic                   isLoadQ;

    assign issue = (state == IDLE) && instrValid && supported;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dataReadySync   <= 1'b0;
            aluCompleteSync <= 1'b0;
        end
        else
        begin
            dataReadySync   <= dataReady;    // One flop as on the bus side
            aluCompleteSync <= aluComplete;
        end
    end

    // Snapshot at issue, instr may change afterwards
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            aluOpQ    <= aluOp;
            loadOpQ   <= loadOp;
            bSrcQ     <= bSrc;
            loadOselQ <= loadOsel;
            immQ      <= decImm;
            rdQ       <= rd;
            isLoadQ   <= isLoad;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= IDLE;
            pcOut    <= `PC_RESET;
            immValue <= '0;
            rs1Out   <= '0;
            rs2Out   <= '0;
            rdOut    <= '0;
            aluSel   <= ALU_ADD;
            aSel     <= ASEL_DECODER;
            bSel     <= BSEL_DECODER;
            oSel     <= OSEL_ALU;
            aEnable  <= 1'b0;
            bEnable  <= 1'b0;
            rdWrite  <= 1'b0;
            memRead  <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (issue)  // Unsupported words never leave IDLE
                    begin
                        rs1Out <= rs1;
                        rs2Out <= usesRs2 ? rs2 : '0;
                        state  <= FETCH;
                    end
                end
                FETCH:
                begin
                    if (dataReadySync)  // Operands on the bus
                    begin
                        aSel     <= ASEL_BUS;
                        bSel     <= bSrcQ;
                        immValue <= immQ;
                        aluSel   <= aluOpQ;
                        aEnable  <= 1'b1;
                        bEnable  <= 1'b1;
                        state    <= EXECUTE;
                    end
                end
                EXECUTE:
                begin
                    if (aluCompleteSync && isLoadQ)
                    begin
                        memRead <= 1'b1;  // ALU result is the address
                        state   <= MEMORY;
                    end
                    else if (aluCompleteSync)
                    begin
                        oSel    <= OSEL_ALU;
                        rdOut   <= rdQ;
                        rdWrite <= 1'b1;
                        pcOut   <= pcIn + PC_STEP;
                        state   <= WRITEBACK;
                    end
                end
                MEMORY:
                begin
                    if (memAck)
                    begin
                        memRead <= 1'b0;
                        aluSel  <= loadOpQ;    // Byte or half extraction, ADD for LW
                        oSel    <= loadOselQ;
                        rdOut   <= rdQ;
                        rdWrite <= 1'b1;
                        pcOut   <= pcIn + PC_STEP;
                        state   <= WRITEBACK;
                    end
                end
                WRITEBACK:
                begin
                    rdWrite <= 1'b0;  // Single cycle pulse
                    aEnable <= 1'b0;
                    bEnable <= 1'b0;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/instrDecoder.sv
// Purely combinational, only opcodes 3, 19 and 51 are reported as supported
`include "ctrl_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire riscvIsaPkg::instrWord_u instr,
    output datapathCtrlPkg::aluOp_e      aluOp,     // Operation for the execute phase
    output datapathCtrlPkg::aluOp_e      loadOp,    // Extraction after the memory read
    output datapathCtrlPkg::bSel_e       bSrc,
    output datapathCtrlPkg::oSel_e       loadOsel,
    output logic [`XLEN-1:0]             immValue,
    output logic [`REG_ADDR_W-1:0]       rs1,
    output logic [`REG_ADDR_W-1:0]       rs2,
    output logic [`REG_ADDR_W-1:0]       rd,
    output logic                         isLoad,
    output logic                         usesRs2,
    output logic                         supported
);
    import riscvIsaPkg::*;
    import datapathCtrlPkg::*;

    funct3_e                        f3;
    logic [`IMM12_W-`SHAMT_W-1:0]   immUpper;   // Same bits as funct7 in the R view
    logic                           immShift;
    logic [`XLEN-1:0]               immSext;
    logic [`XLEN-1:0]               immShamt;

    // Shared funct3 map, alt picks SUB or SRA
    function automatic aluOp_e aluFromFunct3(input funct3_e code, input logic alt);
        aluOp_e op;
        op = ALU_ADD;
        case (code)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
        endcase
        return op;
    endfunction

    assign f3       = instr.r.funct3;
    assign rs1      = instr.r.rs1;
    assign rs2      = instr.r.rs2;
    assign rd       = instr.r.rd;
    assign immUpper = instr.i.imm12[`IMM12_W-1:`SHAMT_W];
    assign immShift = (f3 == F3_SLL) || (f3 == F3_SRL);

    // Sign extend imm12
    assign immSext  = {{(`XLEN-`IMM12_W){instr.i.imm12[`IMM12_W-1]}}, instr.i.imm12};
    // Shifts take only the shift amount
    assign immShamt = {{(`XLEN-`SHAMT_W){1'b0}}, instr.i.imm12[`SHAMT_W-1:0]};

    always_comb
    begin
        aluOp     = ALU_ADD;
        loadOp    = ALU_ADD;
        loadOsel  = OSEL_ALU;
        bSrc      = BSEL_IMM;
        immValue  = immSext;
        isLoad    = 1'b0;
        usesRs2   = 1'b0;
        supported = 1'b0;

        case (instr.r.opcode)
            OP_REG:
            begin
                usesRs2  = 1'b1;
                bSrc     = BSEL_BUS;
                immValue = '0;  // Unused for register ops
                aluOp    = aluFromFunct3(f3, instr.r.funct7 == FUNCT7_ALT);
                // ALT only legal for SUB and SRA
                supported = (instr.r.funct7 == FUNCT7_BASE) ||
                            ((instr.r.funct7 == FUNCT7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SRL)));
            end
            OP_IMM:
            begin
                aluOp = aluFromFunct3(f3, immShift && (immUpper == FUNCT7_ALT));
                if (immShift)
                begin
                    immValue  = immShamt;
                    supported = (immUpper == FUNCT7_BASE) ||
                                ((f3 == F3_SRL) && (immUpper == FUNCT7_ALT));
                end
                else
                begin
                    supported = 1'b1;  // No SUBI, so ADDI ignores the upper bits
                end
            end
            OP_LOAD:
            begin
                isLoad    = 1'b1;  // Address is rs1 + imm through ALU_ADD
                supported = 1'b1;
                case (f3)
                    F3_LB:   loadOp = ALU_LB;
                    F3_LH:   loadOp = ALU_LH;
                    F3_LW:   loadOsel = OSEL_REGA;  // Full word bypasses the ALU
                    F3_LBU:  loadOp = ALU_LBU;
                    F3_LHU:  loadOp = ALU_LHU;
                    default: supported = 1'b0;  // funct3 3, 6, 7
                endcase
            end
            default: supported = 1'b0;  // Unknown opcode
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/riscvIsaPkg.sv
// RV32I base encodings for the register, immediate and load groups only
`include "ctrl_defines.svh"
`default_nettype none

package riscvIsaPkg;

    // Major opcodes kept by the control unit
    typedef enum logic [6:0] {
        OP_LOAD = 7'd3,   // LB LH LW LBU LHU
        OP_IMM  = 7'd19,  // ALU op with I-type immediate
        OP_REG  = 7'd51   // ALU op on two registers
    } opcode_e;

    // ALU function codes
    typedef enum logic [2:0] {
        F3_ADD  = 3'd0,  // ADD or SUB
        F3_SLL  = 3'd1,
        F3_SLT  = 3'd2,
        F3_SLTU = 3'd3,
        F3_XOR  = 3'd4,
        F3_SRL  = 3'd5,  // SRL or SRA
        F3_OR   = 3'd6,
        F3_AND  = 3'd7
    } funct3_e;

    // Load widths share the same funct3 codes
    parameter funct3_e F3_LB  = F3_ADD;
    parameter funct3_e F3_LH  = F3_SLL;
    parameter funct3_e F3_LW  = F3_SLT;
    parameter funct3_e F3_LBU = F3_XOR;
    parameter funct3_e F3_LHU = F3_SRL;

    // Only two funct7 values are legal here
    parameter logic [6:0] FUNCT7_BASE = 7'd0;
    parameter logic [6:0] FUNCT7_ALT  = 7'd32;  // SUB and SRA

    // Register-register layout
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e                funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;  // Left plain so unknown codes stay visible
    } rTypeFields_t;

    // Immediate layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [`IMM12_W-1:0]    imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e                funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } iTypeFields_t;

    // One instruction word, two views
    typedef union packed {
        rTypeFields_t r;
        iTypeFields_t i;
    } instrWord_u;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tbControlUnit -o simControlUnit

./obj_dir/simControlUnit > sim.log
cat sim.log

if grep -q "Regression failed" sim.log
then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"

// File: tests/tbControlUnit.sv
// Assumes one instruction in flight and a responder that drops its levels once it sees rdWrite
`include "ctrl_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit;
    import datapathCtrlPkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int STEP_TIMEOUT  = 200;  // Cycles allowed for one instruction
    localparam int IDLE_WINDOW   = 12;   // Cycles watched after an unsupported word
    localparam int NUM_INSTR     = 39;
    localparam int WORST_CYCLES  = 80;   // Three waits of up to 20 cycles plus FSM steps
    localparam int MARGIN_CYCLES = 500;
    localparam int WATCHDOG_NS   = (NUM_INSTR * WORST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic [`XLEN-1:0]       instr = '0;
    logic                   instrValid = 1'b0;
    logic [`XLEN-1:0]       pcIn = '0;
    logic                   dataReady = 1'b0;
    logic                   aluComplete = 1'b0;
    logic                   memAck = 1'b0;
    logic [`XLEN-1:0]       pcOut;
    logic [`XLEN-1:0]       immValue;
    logic [`REG_ADDR_W-1:0] rs1Out;
    logic [`REG_ADDR_W-1:0] rs2Out;
    logic [`REG_ADDR_W-1:0] rdOut;
    aluOp_e                 aluSel;
    aSel_e                  aSel;
    bSel_e                  bSel;
    oSel_e                  oSel;
    logic                   aEnable;
    logic                   bEnable;
    logic                   rdWrite;
    logic                   memRead;

    int               maxStall = 3;   // Upper bound of each responder delay
    int               drWait = 0;
    int               acWait = 0;
    int               maWait = 0;
    int               errorCount = 0;
    int               checkCount = 0;
    int               testCount = 0;
    logic [`XLEN-1:0] expPc = '0;     // pcIn offered with the current instruction
    logic             sawMemRead = 1'b0;

    controlUnit DUT (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instrValid  (instrValid),
        .pcIn        (pcIn),
        .dataReady   (dataReady),
        .aluComplete (aluComplete),
        .memAck      (memAck),
        .pcOut       (pcOut),
        .immValue    (immValue),
        .rs1Out      (rs1Out),
        .rs2Out      (rs2Out),
        .rdOut       (rdOut),
        .aluSel      (aluSel),
        .aSel        (aSel),
        .bSel        (bSel),
        .oSel        (oSel),
        .aEnable     (aEnable),
        .bEnable     (bEnable),
        .rdWrite     (rdWrite),
        .memRead     (memRead)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Datapath model raising each level after a random delay and clearing it after writeback
    always @(posedge clk)
    begin
        if (reset || !instrValid || rdWrite)
        begin
            dataReady   <= 1'b0;
            aluComplete <= 1'b0;
            memAck      <= 1'b0;
            drWait      <= $urandom_range(maxStall, 0);
            acWait      <= $urandom_range(maxStall, 0);
            maWait      <= $urandom_range(maxStall, 0);
        end
        else
        begin
            if (drWait == 0)
                dataReady <= 1'b1;  // Operands on the bus
            else
                drWait <= drWait - 1;
            if (aEnable && acWait == 0)
                aluComplete <= 1'b1;
            else if (aEnable)
                acWait <= acWait - 1;
            if (memRead && maWait == 0)
                memAck <= 1'b1;
            else if (memRead)
                maWait <= maWait - 1;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond)
        else
        begin
            errorCount++;
            $display("Failure at %0t ns: %s", $time, what);
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        $display("Test %-12s %s, %0d errors", name,
                 (errorCount == startErrors) ? "ok" : "with errors", errorCount - startErrors);
    endtask

    // Standard RV32 layouts
    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'd51};
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    // Offer one word and wait for rdWrite, watching memRead order and pcOut on the way
    task automatic runInstr(input logic [31:0] word, output logic done);
        int               waitCycles;
        logic             sawAluComplete;
        logic             prevMemRead;
        logic             prevMemAck;
        logic [`XLEN-1:0] pcBefore;
        done           = 1'b0;
        waitCycles     = 0;
        sawAluComplete = 1'b0;
        prevMemRead    = 1'b0;
        prevMemAck     = 1'b0;
        sawMemRead     = 1'b0;
        @(negedge clk);
        pcBefore = pcOut;
        expPc    = $urandom;
        @(posedge clk);
        instr      <= word;
        instrValid <= 1'b1;
        pcIn       <= expPc;
        while (!done && waitCycles < STEP_TIMEOUT)
        begin
            @(negedge clk);
            waitCycles++;
            sawAluComplete = sawAluComplete | aluComplete;
            if (memRead)
            begin
                sawMemRead = 1'b1;
                checkTrue(sawAluComplete, "memRead raised before aluComplete");
            end
            if (prevMemRead && !memRead)
                checkTrue(prevMemAck, "memRead dropped before memAck");
            if (rdWrite)
                done = 1'b1;
            else
                checkValue("pcOut", pcOut, pcBefore);  // No advance before writeback
            prevMemRead = memRead;
            prevMemAck  = memAck;
        end
        if (!done)
            checkTrue(1'b0, "Timed out waiting for rdWrite");
    endtask

    task automatic finishInstr();
        @(posedge clk);
        instrValid <= 1'b0;  // Dropped in the cycle rdWrite is seen
        @(negedge clk);
        checkTrue(!rdWrite, "rdWrite high for more than one cycle");
        checkTrue(!aEnable && !bEnable, "Operand enables still high after writeback");
    endtask

    // Values shared by every writeback cycle
    task automatic checkWriteback(input aluOp_e expAlu, input bSel_e expB, input oSel_e expO,
                                  input logic [4:0] expRs1, input logic [4:0] expRd);
        checkValue("aluSel", 32'(aluSel), 32'(expAlu));
        checkValue("aSel", 32'(aSel), 32'(ASEL_BUS));
        checkValue("bSel", 32'(bSel), 32'(expB));
        checkValue("oSel", 32'(oSel), 32'(expO));
        checkValue("rs1Out", 32'(rs1Out), 32'(expRs1));
        checkValue("rdOut", 32'(rdOut), 32'(expRd));
        checkValue("aEnable", 32'(aEnable), 1);  // Raised at operand fetch until writeback ends
        checkValue("bEnable", 32'(bEnable), 1);
        checkValue("memRead", 32'(memRead), 0);
        checkValue("pcOut", pcOut, expPc + 1);
    endtask

    task automatic runRegOp(input logic [6:0] f7, input logic [2:0] f3, input aluOp_e expAlu);
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic       done;
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        rd  = 5'($urandom);
        runInstr(encodeR(f7, rs2, rs1, f3, rd), done);
        if (done)
        begin
            checkWriteback(expAlu, BSEL_BUS, OSEL_ALU, rs1, rd);
            checkValue("rs2Out", 32'(rs2Out), 32'(rs2));
        end
        finishInstr();
    endtask

    task automatic runImmOp(input logic [2:0] f3, input logic [11:0] imm,
                            input aluOp_e expAlu, input logic isShift);
        logic [4:0]       rs1;
        logic [4:0]       rd;
        logic             done;
        logic [`XLEN-1:0] expImm;
        rs1 = 5'($urandom);
        rd  = 5'($urandom);
        if (isShift)
            expImm = {{(`XLEN-`SHAMT_W){1'b0}}, imm[`SHAMT_W-1:0]};  // Shift amount only
        else
            expImm = {{(`XLEN-`IMM12_W){imm[11]}}, imm};
        runInstr(encodeI(imm, rs1, f3, rd, 7'd19), done);
        if (done)
        begin
            checkWriteback(expAlu, BSEL_IMM, OSEL_ALU, rs1, rd);
            checkValue("immValue", immValue, expImm);
        end
        finishInstr();
    endtask

    task automatic runLoad(input logic [2:0] f3, input aluOp_e expAlu, input oSel_e expO);
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic        done;
        imm = 12'($urandom);
        rs1 = 5'($urandom);
        rd  = 5'($urandom);
        runInstr(encodeI(imm, rs1, f3, rd, 7'd3), done);
        if (done)
        begin
            checkWriteback(expAlu, BSEL_IMM, expO, rs1, rd);
            checkValue("immValue", immValue, {{(`XLEN-`IMM12_W){imm[11]}}, imm});
            checkTrue(sawMemRead, "Load completed without memRead");
        end
        finishInstr();
    endtask

    // Sequencer must stay idle for the whole window
    task automatic runUnsupported(input logic [31:0] word);
        logic [`XLEN-1:0] pcBefore;
        @(negedge clk);
        pcBefore = pcOut;
        @(posedge clk);
        instr      <= word;
        instrValid <= 1'b1;
        pcIn       <= $urandom;
        repeat (IDLE_WINDOW)
        begin
            @(negedge clk);
            checkTrue(!rdWrite && !memRead && !aEnable && !bEnable,
                      "Unsupported encoding started the sequencer");
            checkValue("pcOut", pcOut, pcBefore);
        end
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    task automatic testReset();
        int startErrors;
        startErrors = errorCount;
        @(negedge clk);
        checkValue("rdWrite", 32'(rdWrite), 0);
        checkValue("memRead", 32'(memRead), 0);
        checkValue("aEnable", 32'(aEnable), 0);
        checkValue("bEnable", 32'(bEnable), 0);
        checkValue("aluSel", 32'(aluSel), 0);
        checkValue("aSel", 32'(aSel), 0);
        checkValue("bSel", 32'(bSel), 0);
        checkValue("oSel", 32'(oSel), 0);
        checkValue("rs1Out", 32'(rs1Out), 0);
        checkValue("rs2Out", 32'(rs2Out), 0);
        checkValue("rdOut", 32'(rdOut), 0);
        checkValue("immValue", immValue, 0);
        checkValue("pcOut", pcOut, `PC_RESET);
        reportTest("reset", startErrors);
    endtask

    task automatic testRegOps();
        int startErrors;
        startErrors = errorCount;
        runRegOp(7'd0, 3'd0, ALU_ADD);
        runRegOp(7'd32, 3'd0, ALU_SUB);
        runRegOp(7'd0, 3'd1, ALU_SLL);
        runRegOp(7'd0, 3'd2, ALU_SLT);
        runRegOp(7'd0, 3'd3, ALU_SLTU);
        runRegOp(7'd0, 3'd4, ALU_XOR);
        runRegOp(7'd0, 3'd5, ALU_SRL);
        runRegOp(7'd32, 3'd5, ALU_SRA);
        runRegOp(7'd0, 3'd6, ALU_OR);
        runRegOp(7'd0, 3'd7, ALU_AND);
        reportTest("regOps", startErrors);
    endtask

    task automatic testImmOps();
        int startErrors;
        startErrors = errorCount;
        runImmOp(3'd0, {7'd32, 5'($urandom)}, ALU_ADD, 1'b0);  // Positive imm12 with SRAI upper bits
        runImmOp(3'd0, {1'b1, 11'($urandom)}, ALU_ADD, 1'b0);  // Negative imm12
        runImmOp(3'd2, 12'($urandom), ALU_SLT, 1'b0);
        runImmOp(3'd3, 12'($urandom), ALU_SLTU, 1'b0);
        runImmOp(3'd4, 12'($urandom), ALU_XOR, 1'b0);
        runImmOp(3'd6, 12'($urandom), ALU_OR, 1'b0);
        runImmOp(3'd7, 12'($urandom), ALU_AND, 1'b0);
        runImmOp(3'd1, {7'd0, 5'($urandom)}, ALU_SLL, 1'b1);
        runImmOp(3'd5, {7'd0, 5'($urandom)}, ALU_SRL, 1'b1);
        runImmOp(3'd5, {7'd32, 5'($urandom)}, ALU_SRA, 1'b1);  // Upper bits pick SRAI
        reportTest("immOps", startErrors);
    endtask

    task automatic testLoads();
        int startErrors;
        startErrors = errorCount;
        runLoad(3'd0, ALU_LB, OSEL_ALU);
        runLoad(3'd1, ALU_LH, OSEL_ALU);
        runLoad(3'd2, ALU_ADD, OSEL_REGA);  // LW takes the raw word
        runLoad(3'd4, ALU_LBU, OSEL_ALU);
        runLoad(3'd5, ALU_LHU, OSEL_ALU);
        reportTest("loads", startErrors);
    endtask

    task automatic testStalls();
        int startErrors;
        startErrors = errorCount;
        maxStall = 20;
        for (int i = 0; i < 8; i++)
        begin
            if (i % 2 == 0)
                runRegOp(7'd0, 3'd0, ALU_ADD);
            else
                runLoad(3'd2, ALU_ADD, OSEL_REGA);
        end
        maxStall = 3;
        reportTest("stalls", startErrors);
    endtask

    task automatic testUnsupported();
        int startErrors;
        startErrors = errorCount;
        runUnsupported(encodeI(12'($urandom), 5'd1, 3'd3, 5'd2, 7'd3));  // Load funct3 3
        runRegOp(7'd0, 3'd7, ALU_AND);
        runUnsupported(encodeR(7'd1, 5'd3, 5'd4, 3'd0, 5'd5));           // Bad funct7
        runRegOp(7'd0, 3'd6, ALU_OR);
        runUnsupported({25'($urandom), 7'd55});                          // LUI is not kept
        runRegOp(7'd32, 3'd0, ALU_SUB);
        reportTest("unsupported", startErrors);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        void'($urandom(94712));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        testReset();
        testRegOps();
        testImmOps();
        testLoads();
        testStalls();
        testUnsupported();
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
